//--- source/conv_dw_pkg.sv
package conv_dw_pkg;

    //////////////////////////////////////////////////////////////////////
    // layer geometry
    //////////////////////////////////////////////////////////////////////
    localparam int FMAP_SIZE = 14;   // input height / width
    localparam int KERNEL    = 3;    // 3x3 depthwise filter
    localparam int STRIDE    = 2;
    localparam int PADDING   = 1;
    localparam int CHANNELS  = 64;   // one filter per group

    // output side, follows from the above (7)
    localparam int OUT_SIZE  = (FMAP_SIZE + 2 * PADDING - KERNEL) / STRIDE + 1;
    localparam int TAPS      = KERNEL * KERNEL;   // weight words per channel

    localparam int MEM_LATENCY = 2;  // bank read latency, cycles

    // counter widths
    localparam int CH_W  = $clog2(CHANNELS);
    localparam int OUT_W = $clog2(OUT_SIZE);
    localparam int K_W   = $clog2(KERNEL);

    // bus words
    typedef logic [7:0]  data_t;
    typedef logic [15:0] paddr_t;   // param rom
    typedef logic [14:0] faddr_t;   // fmap bank

    // bank map
    localparam paddr_t PARAM_BASE_ADDR  = 16'h1240;  // this layer's weights
    localparam faddr_t INPUT_BASE_ADDR  = 15'h0000;
    localparam faddr_t OUTPUT_BASE_ADDR = 15'h4000;

    // sequencer -> address gen
    typedef struct packed {
        logic             valid;
        logic [CH_W-1:0]  channel;
        logic [OUT_W-1:0] out_row;
        logic [OUT_W-1:0] out_col;
        logic [K_W-1:0]   k_row;
        logic [K_W-1:0]   k_col;
        logic             first;      // tap 0 of window
        logic             last;       // tap 8 of window
        logic             final_tap;  // last tap of layer
    } tap_pos_t;

    // address gen -> align -> mac
    typedef struct packed {
        logic   valid;
        logic   pad;        // tap in padding, no pixel read
        logic   first;
        logic   last;
        logic   final_tap;
        faddr_t waddr;      // where the window result goes
    } tap_ctrl_t;

    // mac -> writeback
    typedef struct packed {
        logic   valid;
        logic   final_word;
        faddr_t waddr;
        data_t  value;
    } out_word_t;

endpackage

//--- source/tap_sequencer.sv
`timescale 1ns/1ps

module tap_sequencer (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 init,   // start pulse, ignored while busy
    output logic                 busy,
    output conv_dw_pkg::tap_pos_t tap
);

    // wrap points of each counter
    localparam logic [conv_dw_pkg::K_W-1:0]   K_LAST =
        conv_dw_pkg::K_W'(conv_dw_pkg::KERNEL - 1);
    localparam logic [conv_dw_pkg::OUT_W-1:0] O_LAST =
        conv_dw_pkg::OUT_W'(conv_dw_pkg::OUT_SIZE - 1);
    localparam logic [conv_dw_pkg::CH_W-1:0]  C_LAST =
        conv_dw_pkg::CH_W'(conv_dw_pkg::CHANNELS - 1);

    logic [conv_dw_pkg::K_W-1:0]   k_col;
    logic [conv_dw_pkg::K_W-1:0]   k_row;
    logic [conv_dw_pkg::OUT_W-1:0] o_col;
    logic [conv_dw_pkg::OUT_W-1:0] o_row;
    logic [conv_dw_pkg::CH_W-1:0]  ch;

    logic win_first;
    logic win_last;
    logic layer_last;

    //////////////////////////////////////////////////////////////////////
    // tap flags
    //////////////////////////////////////////////////////////////////////
    assign win_first  = (k_row == '0) && (k_col == '0);
    assign win_last   = (k_row == K_LAST) && (k_col == K_LAST);
    assign layer_last = win_last && (o_row == O_LAST) && (o_col == O_LAST)
                        && (ch == C_LAST);

    // tap straight off the counters
    always_comb begin
        tap.valid     = busy;
        tap.channel   = ch;
        tap.out_row   = o_row;
        tap.out_col   = o_col;
        tap.k_row     = k_row;
        tap.k_col     = k_col;
        tap.first     = win_first;
        tap.last      = win_last;
        tap.final_tap = layer_last;
    end

    //////////////////////////////////////////////////////////////////////
    // nested counters, kernel col innermost
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy  <= 1'b0;
            k_col <= '0;
            k_row <= '0;
            o_col <= '0;
            o_row <= '0;
            ch    <= '0;
        end else if (!busy) begin
            if (init) begin
                busy  <= 1'b1;     // first tap out next cycle
                k_col <= '0;
                k_row <= '0;
                o_col <= '0;
                o_row <= '0;
                ch    <= '0;
            end
        end else begin
            if (layer_last)
                busy <= 1'b0;      // counters all wrap to 0 here
            if (k_col == K_LAST) begin
                k_col <= '0;
                if (k_row == K_LAST) begin
                    k_row <= '0;
                    // window done, next output pixel
                    if (o_col == O_LAST) begin
                        o_col <= '0;
                        if (o_row == O_LAST) begin
                            o_row <= '0;
                            ch    <= (ch == C_LAST) ? '0 : ch + 1'b1;  // next plane
                        end else begin
                            o_row <= o_row + 1'b1;
                        end
                    end else begin
                        o_col <= o_col + 1'b1;
                    end
                end else begin
                    k_row <= k_row + 1'b1;
                end
            end else begin
                k_col <= k_col + 1'b1;
            end
        end
    end

endmodule

//--- source/bank_address_gen.sv
`timescale 1ns/1ps

module bank_address_gen #(
    parameter conv_dw_pkg::paddr_t PARAM_BASE_ADDR = conv_dw_pkg::PARAM_BASE_ADDR
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  conv_dw_pkg::tap_pos_t  tap,
    output conv_dw_pkg::paddr_t    pbank_addr,
    output logic                   pbank_en,
    output conv_dw_pkg::faddr_t    fbank_raddr,
    output logic                   fbank_ren,
    output conv_dw_pkg::tap_ctrl_t ctrl
);

    // words per plane
    localparam int IN_PLANE  = conv_dw_pkg::FMAP_SIZE * conv_dw_pkg::FMAP_SIZE;  // 196
    localparam int OUT_PLANE = conv_dw_pkg::OUT_SIZE * conv_dw_pkg::OUT_SIZE;    // 49

    int in_row;   // may go to -1 at the top/left border
    int in_col;
    logic pad;

    conv_dw_pkg::paddr_t p_addr;
    conv_dw_pkg::faddr_t r_addr;
    conv_dw_pkg::faddr_t w_addr;

    //////////////////////////////////////////////////////////////////////
    // tap -> input coordinate and addresses
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        in_row = conv_dw_pkg::STRIDE * int'(tap.out_row) + int'(tap.k_row)
                 - conv_dw_pkg::PADDING;
        in_col = conv_dw_pkg::STRIDE * int'(tap.out_col) + int'(tap.k_col)
                 - conv_dw_pkg::PADDING;
        pad    = (in_row < 0) || (in_row >= conv_dw_pkg::FMAP_SIZE) ||
                 (in_col < 0) || (in_col >= conv_dw_pkg::FMAP_SIZE);

        // constant multiplies, reduce to shift/add
        p_addr = PARAM_BASE_ADDR
               + conv_dw_pkg::paddr_t'(tap.channel) * conv_dw_pkg::paddr_t'(conv_dw_pkg::TAPS)
               + conv_dw_pkg::paddr_t'(tap.k_row) * conv_dw_pkg::paddr_t'(conv_dw_pkg::KERNEL)
               + conv_dw_pkg::paddr_t'(tap.k_col);

        if (pad) begin
            r_addr = '0;              // nothing read on a padded tap
        end else begin
            r_addr = conv_dw_pkg::INPUT_BASE_ADDR
                   + conv_dw_pkg::faddr_t'(tap.channel) * conv_dw_pkg::faddr_t'(IN_PLANE)
                   + conv_dw_pkg::faddr_t'(in_row)
                     * conv_dw_pkg::faddr_t'(conv_dw_pkg::FMAP_SIZE)
                   + conv_dw_pkg::faddr_t'(in_col);
        end

        w_addr = conv_dw_pkg::OUTPUT_BASE_ADDR
               + conv_dw_pkg::faddr_t'(tap.channel) * conv_dw_pkg::faddr_t'(OUT_PLANE)
               + conv_dw_pkg::faddr_t'(tap.out_row)
                 * conv_dw_pkg::faddr_t'(conv_dw_pkg::OUT_SIZE)
               + conv_dw_pkg::faddr_t'(tap.out_col);
    end

    //////////////////////////////////////////////////////////////////////
    // port regs, ctrl launched same edge
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pbank_en  <= 1'b0;
            fbank_ren <= 1'b0;
            ctrl      <= '0;
        end else begin
            pbank_en       <= tap.valid;           // weight read every tap
            fbank_ren      <= tap.valid & ~pad;
            ctrl.valid     <= tap.valid;
            ctrl.pad       <= pad;
            ctrl.first     <= tap.first;
            ctrl.last      <= tap.last;
            ctrl.final_tap <= tap.final_tap;
            ctrl.waddr     <= w_addr;
        end
    end

    always_ff @(posedge clk) begin
        pbank_addr  <= p_addr;
        fbank_raddr <= r_addr;
    end

endmodule

//--- source/latency_align.sv
`timescale 1ns/1ps

module latency_align #(
    parameter int DEPTH = conv_dw_pkg::MEM_LATENCY   // >= 1
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  conv_dw_pkg::tap_ctrl_t ctrl_in,
    output conv_dw_pkg::tap_ctrl_t ctrl_out
);

    // one slot per cycle of bank latency
    conv_dw_pkg::tap_ctrl_t pipe [DEPTH];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;          // no taps in flight
            end
        end else begin
            pipe[0] <= ctrl_in;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];   // shift toward the mac
            end
        end
    end

    // lines up with pdata / fdata_r
    assign ctrl_out = pipe[DEPTH-1];

endmodule

//--- source/mac_accumulate.sv
`timescale 1ns/1ps

module mac_accumulate (
    input  logic                   clk,
    input  logic                   rstn,
    input  conv_dw_pkg::tap_ctrl_t ctrl,     // aligned with bank data
    input  conv_dw_pkg::data_t     weight,   // pdata
    input  conv_dw_pkg::data_t     pixel,    // fdata_r
    output conv_dw_pkg::out_word_t word
);

    logic [15:0]        prod;       // full product
    conv_dw_pkg::data_t term;       // what this tap adds
    conv_dw_pkg::data_t base;
    conv_dw_pkg::data_t sum_next;
    conv_dw_pkg::data_t acc;        // running window sum

    //////////////////////////////////////////////////////////////////////
    // multiply / add, 8 bit wrap
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        prod = weight * pixel;
        // padded tap reads no pixel, contributes zero
        term = ctrl.pad ? '0 : prod[7:0];
        // first tap of a window starts over
        base = ctrl.first ? '0 : acc;
        sum_next = base + term;
    end

    // accumulator only moves on valid taps
    always_ff @(posedge clk) begin
        if (ctrl.valid) begin
            acc <= sum_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // emit on last tap
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            word <= '0;
        end else begin
            word.valid      <= ctrl.valid & ctrl.last;   // one word per 9 taps
            word.final_word <= ctrl.valid & ctrl.final_tap;
            word.waddr      <= ctrl.waddr;
            word.value      <= sum_next;    // includes the last tap itself
        end
    end

endmodule

//--- source/fmap_writeback.sv
`timescale 1ns/1ps

module fmap_writeback (
    input  logic                   clk,
    input  logic                   rstn,
    input  conv_dw_pkg::out_word_t word,
    output conv_dw_pkg::faddr_t    fbank_waddr,
    output conv_dw_pkg::data_t     fdata_w,
    output logic                   fbank_wen,
    output logic                   done
);

    logic wr_final;   // write in progress is the layer's last

    //////////////////////////////////////////////////////////////////////
    // write strobe and completion
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            fbank_wen <= 1'b0;
            wr_final  <= 1'b0;
            done      <= 1'b0;
        end else begin
            fbank_wen <= word.valid;                       // one cycle per word
            wr_final  <= word.valid & word.final_word;
            done      <= fbank_wen & wr_final;             // cycle after final write
        end
    end

    // write payload
    always_ff @(posedge clk) begin
        fbank_waddr <= word.waddr;
        fdata_w     <= word.value;
    end

endmodule

//--- source/conv2_dw.sv
`timescale 1ns/1ps

module conv2_dw #(
    parameter int                  MEM_LATENCY     = conv_dw_pkg::MEM_LATENCY,
    parameter conv_dw_pkg::paddr_t PARAM_BASE_ADDR = conv_dw_pkg::PARAM_BASE_ADDR
) (
    input  logic                clk,
    input  logic                rstn,

    // control
    input  logic                init,
    output logic                done,

    // param rom
    output conv_dw_pkg::paddr_t pbank_addr,
    output logic                pbank_en,
    input  conv_dw_pkg::data_t  pdata,

    // fmap read
    output conv_dw_pkg::faddr_t fbank_raddr,
    output logic                fbank_ren,
    input  conv_dw_pkg::data_t  fdata_r,

    // fmap write
    output conv_dw_pkg::faddr_t fbank_waddr,
    output conv_dw_pkg::data_t  fdata_w,
    output logic                fbank_wen
);

    logic                   busy;       // layer running
    conv_dw_pkg::tap_pos_t  tap;
    conv_dw_pkg::tap_ctrl_t ctrl_issue; // leaves with the read
    conv_dw_pkg::tap_ctrl_t ctrl_data;  // meets the read data
    conv_dw_pkg::out_word_t word;

    //////////////////////////////////////////////////////////////////////
    // tap pipeline
    //////////////////////////////////////////////////////////////////////
    tap_sequencer u_seq (
        .clk  (clk),
        .rstn (rstn),
        .init (init),
        .busy (busy),
        .tap  (tap)
    );

    bank_address_gen #(
        .PARAM_BASE_ADDR (PARAM_BASE_ADDR)
    ) u_addr (
        .clk         (clk),
        .rstn        (rstn),
        .tap         (tap),
        .pbank_addr  (pbank_addr),
        .pbank_en    (pbank_en),
        .fbank_raddr (fbank_raddr),
        .fbank_ren   (fbank_ren),
        .ctrl        (ctrl_issue)
    );

    latency_align #(
        .DEPTH (MEM_LATENCY)
    ) u_align (
        .clk      (clk),
        .rstn     (rstn),
        .ctrl_in  (ctrl_issue),
        .ctrl_out (ctrl_data)
    );

    mac_accumulate u_mac (
        .clk    (clk),
        .rstn   (rstn),
        .ctrl   (ctrl_data),
        .weight (pdata),
        .pixel  (fdata_r),
        .word   (word)
    );

    fmap_writeback u_wb (
        .clk         (clk),
        .rstn        (rstn),
        .word        (word),
        .fbank_waddr (fbank_waddr),
        .fdata_w     (fdata_w),
        .fbank_wen   (fbank_wen),
        .done        (done)
    );

endmodule

//--- test/conv2_dw_bank_model.sv
`timescale 1ns/1ps

module conv2_dw_bank_model #(
    parameter int LATENCY = conv_dw_pkg::MEM_LATENCY
) (
    input  logic                clk,
    input  conv_dw_pkg::paddr_t pbank_addr,
    input  logic                pbank_en,
    output conv_dw_pkg::data_t  pdata,
    input  conv_dw_pkg::faddr_t fbank_raddr,
    input  logic                fbank_ren,
    output conv_dw_pkg::data_t  fdata_r,
    input  conv_dw_pkg::faddr_t fbank_waddr,
    input  conv_dw_pkg::data_t  fdata_w,
    input  logic                fbank_wen
);

    conv_dw_pkg::data_t rom [65536];   // param rom
    conv_dw_pkg::data_t ram [32768];   // fmap bank, in and out regions
    conv_dw_pkg::data_t p_pipe [LATENCY];
    conv_dw_pkg::data_t f_pipe [LATENCY];

    // address-keyed background, then random weights over the block
    task automatic fill_weights(input conv_dw_pkg::paddr_t base);
        for (int a = 0; a < 65536; a++) begin
            rom[a] = conv_dw_pkg::data_t'(a[7:0] ^ a[15:8]);
        end
        for (int i = 0; i < conv_dw_pkg::CHANNELS * conv_dw_pkg::TAPS; i++) begin
            rom[base + i] = conv_dw_pkg::data_t'($urandom);
        end
    endtask

    task automatic fill_fmap();
        for (int a = 0; a < 32768; a++) begin
            ram[a] = conv_dw_pkg::data_t'($urandom);
        end
    endtask

    always @(posedge clk) begin
        if (pbank_en) p_pipe[0] <= rom[pbank_addr];
        if (fbank_ren) f_pipe[0] <= ram[fbank_raddr];
        for (int i = 1; i < LATENCY; i++) begin
            p_pipe[i] <= p_pipe[i-1];   // read latency
            f_pipe[i] <= f_pipe[i-1];
        end
        if (fbank_wen) ram[fbank_waddr] <= fdata_w;
    end

    assign pdata   = p_pipe[LATENCY-1];
    assign fdata_r = f_pipe[LATENCY-1];

endmodule

//--- test/conv2_dw_tb.sv
`timescale 1ns/1ps

module conv2_dw_tb;

    localparam int N_OUT = conv_dw_pkg::CHANNELS * conv_dw_pkg::OUT_SIZE
                           * conv_dw_pkg::OUT_SIZE;   // 3136 words
    localparam int N_W   = conv_dw_pkg::CHANNELS * conv_dw_pkg::TAPS;
    localparam int N_IN  = conv_dw_pkg::CHANNELS * conv_dw_pkg::FMAP_SIZE
                           * conv_dw_pkg::FMAP_SIZE;
    localparam conv_dw_pkg::paddr_t PB = conv_dw_pkg::PARAM_BASE_ADDR;
    localparam conv_dw_pkg::faddr_t OB = conv_dw_pkg::OUTPUT_BASE_ADDR;

    logic clk, rstn, init, done, pbank_en, fbank_ren, fbank_wen;
    conv_dw_pkg::paddr_t pbank_addr;
    conv_dw_pkg::faddr_t fbank_raddr, fbank_waddr;
    conv_dw_pkg::data_t  pdata, fdata_r, fdata_w;

    conv_dw_pkg::data_t expected [N_OUT];
    logic written [N_OUT];
    int wr_count, done_count, errors, tests, failed, err_mark;
    int tap_idx;      // weight reads seen since init
    logic timed_out;

    conv2_dw uut (.*);
    conv2_dw_bank_model bank (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // tap n of the layer lies in the padding
    function automatic logic tap_padded(input int n);
        int pos;
        int orow;
        int ocol;
        int ir;
        int ic;
        pos  = (n / conv_dw_pkg::TAPS) % (conv_dw_pkg::OUT_SIZE * conv_dw_pkg::OUT_SIZE);
        orow = pos / conv_dw_pkg::OUT_SIZE;
        ocol = pos % conv_dw_pkg::OUT_SIZE;
        ir   = conv_dw_pkg::STRIDE * orow + (n % conv_dw_pkg::TAPS) / conv_dw_pkg::KERNEL
               - conv_dw_pkg::PADDING;
        ic   = conv_dw_pkg::STRIDE * ocol + n % conv_dw_pkg::KERNEL - conv_dw_pkg::PADDING;
        return (ir < 0) || (ir >= conv_dw_pkg::FMAP_SIZE) ||
               (ic < 0) || (ic >= conv_dw_pkg::FMAP_SIZE);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks on every edge
    //////////////////////////////////////////////////////////////////////
    assert property (@(posedge clk) disable iff (!rstn)
        pbank_en |-> (pbank_addr >= PB && pbank_addr < PB + N_W))
        else begin
            errors++;
            $display("Error pbank_addr %h", $sampled(pbank_addr));
        end
    assert property (@(posedge clk) disable iff (!rstn)
        fbank_ren |-> (fbank_raddr < N_IN))
        else begin
            errors++;
            $display("Error fbank_raddr %h", $sampled(fbank_raddr));
        end
    // tap position follows from the count of weight reads
    assert property (@(posedge clk) disable iff (!rstn)
        fbank_ren |-> (pbank_en && !tap_padded(tap_idx)))
        else begin
            errors++;
            $display("pixel read issued on padded or missing tap %0d", $sampled(tap_idx));
        end
    // first tap is the padded corner
    assert property (@(posedge clk) disable iff (!rstn)
        $rose(uut.busy) |=> (pbank_en && !fbank_ren))
        else begin
            errors++;
            $display("first tap read enables wrong after init");
        end
    assert property (@(posedge clk) disable iff (!rstn)
        fbank_wen |-> (fbank_waddr >= OB && fbank_waddr < OB + N_OUT))
        else begin
            errors++;
            $display("Error fbank_waddr %h", $sampled(fbank_waddr));
        end
    assert property (@(posedge clk) disable iff (!rstn)
        fbank_wen |-> (fdata_w == expected[fbank_waddr - OB]))
        else begin
            errors++;
            $display("Error fdata_w at %h: got %h expected %h", $sampled(fbank_waddr),
                     $sampled(fdata_w), expected[$sampled(fbank_waddr) - OB]);
        end
    assert property (@(posedge clk) disable iff (!rstn)
        fbank_wen |-> !written[fbank_waddr - OB])
        else begin
            errors++;
            $display("Error fbank_waddr %h written twice", $sampled(fbank_waddr));
        end
    // done only right after the last write
    assert property (@(posedge clk) disable iff (!rstn)
        done |-> ($past(fbank_wen) && wr_count == N_OUT))
        else begin
            errors++;
            $display("Error wr_count %h at done", $sampled(wr_count));
        end

    always @(posedge clk) begin
        if (fbank_wen) begin
            wr_count <= wr_count + 1;
            written[fbank_waddr - OB] <= 1'b1;
        end
        if (pbank_en) tap_idx <= tap_idx + 1;
        if (done) done_count <= done_count + 1;
    end

    // reference model as 8-bit wrapping sum over non-padded taps
    task automatic compute_expected();
        int ir, ic, idx;
        conv_dw_pkg::data_t acc, w, px;
        for (int c = 0; c < conv_dw_pkg::CHANNELS; c++)
            for (int orow = 0; orow < conv_dw_pkg::OUT_SIZE; orow++)
                for (int ocol = 0; ocol < conv_dw_pkg::OUT_SIZE; ocol++) begin
                    acc = '0;
                    for (int kr = 0; kr < conv_dw_pkg::KERNEL; kr++)
                        for (int kc = 0; kc < conv_dw_pkg::KERNEL; kc++) begin
                            ir = conv_dw_pkg::STRIDE * orow + kr - conv_dw_pkg::PADDING;
                            ic = conv_dw_pkg::STRIDE * ocol + kc - conv_dw_pkg::PADDING;
                            if (ir >= 0 && ir < conv_dw_pkg::FMAP_SIZE &&
                                ic >= 0 && ic < conv_dw_pkg::FMAP_SIZE) begin
                                w  = bank.rom[PB + 9 * c + 3 * kr + kc];
                                px = bank.ram[196 * c + 14 * ir + ic];
                                acc = acc + conv_dw_pkg::data_t'(w * px);
                            end
                        end
                    idx = 49 * c + 7 * orow + ocol;
                    expected[idx] = acc;
                end
        for (int i = 0; i < N_OUT; i++) written[i] = 1'b0;
        wr_count = 0;
        done_count = 0;
        tap_idx = 0;
    endtask

    task automatic pulse_init();
        @(negedge clk) init = 1'b1;
        @(negedge clk) init = 1'b0;
    endtask

    // wait for done and a few idle cycles after it to catch extra pulses
    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < 30000) begin
            @(posedge clk);
            n++;
        end
        if (!done) begin
            $display("timeout: done never came within 30000 cycles");
            timed_out = 1'b1;
            errors++;
        end
        repeat (20) @(posedge clk);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors != err_mark) failed++;
        $display("test %s %s", name, (errors == err_mark) ? "ok" : "FAILED");
        err_mark = errors;
    endtask

    task automatic check_counts();
        assert (wr_count == N_OUT && done_count == 1)
        else begin
            errors++;
            $display("Error wr_count %h done_count %h", wr_count, done_count);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'h1adb));
        rstn = 1'b0;
        init = 1'b0;
        errors = 0;
        tests = 0;
        failed = 0;
        err_mark = 0;
        timed_out = 1'b0;
        bank.fill_fmap();
        bank.fill_weights(PB);
        compute_expected();
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        repeat (3) @(negedge clk);
        assert (!done && !pbank_en && !fbank_ren && !fbank_wen)
        else begin
            errors++;
            $display("outputs not idle after reset");
        end
        end_test("reset");

        pulse_init();
        wait_done();
        check_counts();
        end_test("layer");

        if (!timed_out) begin
            bank.fill_weights(PB);   // new weights over the same map
            compute_expected();
            pulse_init();
            repeat (500) @(negedge clk);
            pulse_init();            // ignored while busy
            wait_done();
            check_counts();
            end_test("restart");
        end

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- conv2_dw.f
source/conv_dw_pkg.sv
source/tap_sequencer.sv
source/bank_address_gen.sv
source/latency_align.sv
source/mac_accumulate.sv
source/fmap_writeback.sv
source/conv2_dw.sv
test/conv2_dw_bank_model.sv
test/conv2_dw_tb.sv
